/* logic/mcoc_pkg.sv */
`default_nettype none

package mcoc_pkg;

	// Bus geometry
	localparam int BUS_AW = 16;	// Address width
	localparam int BUS_DW = 16;	// Data width
	localparam int REG_AW = 4;	// Register index inside a page
	localparam int PAGE_W = BUS_AW - REG_AW;	// Page field, upper address bits

	// Peripheral pages
	localparam logic [PAGE_W-1:0] PAGE_ID   = 12'hff0;	// Identification block
	localparam logic [PAGE_W-1:0] PAGE_PORT = 12'hff1;	// I/O port
	localparam logic [PAGE_W-1:0] PAGE_TIM0 = 12'hff2;	// PWM timer 0
	localparam logic [PAGE_W-1:0] PAGE_TIM1 = 12'hff3;	// PWM timer 1
	localparam logic [PAGE_W-1:0] PAGE_INTC = 12'hff4;	// Interrupt controller

	// Identification constants
	localparam logic [BUS_DW-1:0] ID_CODE    = 16'h1150;	// Chip code
	localparam logic [BUS_DW-1:0] ID_VERSION = 16'h0148;	// Version 1.48
	localparam logic [BUS_DW-1:0] ID_CLK_KHZ = 16'd24000;	// Core clock in kHz
	localparam logic [BUS_DW-1:0] ID_EDITION = "LA";	// Edition letters, ASCII

	localparam logic [REG_AW-1:0] ID_R_CODE    = 4'h0;
	localparam logic [REG_AW-1:0] ID_R_VERSION = 4'h1;
	localparam logic [REG_AW-1:0] ID_R_CLK     = 4'h2;
	localparam logic [REG_AW-1:0] ID_R_EDITION = 4'h3;

	// I/O port
	localparam int PORT_W = 8;	// Port bits
	localparam logic [REG_AW-1:0] PORT_R_OUT = 4'h0;	// Output data
	localparam logic [REG_AW-1:0] PORT_R_ENB = 4'h1;	// Output enables
	localparam logic [REG_AW-1:0] PORT_R_SEL = 4'h2;	// Low/high pin select
	localparam logic [REG_AW-1:0] PORT_R_INP = 4'h3;	// Synchronized input, read only

	// PWM timer
	localparam logic [REG_AW-1:0] TIM_R_CTRL   = 4'h0;	// Bit 0 enables counting
	localparam logic [REG_AW-1:0] TIM_R_PERIOD = 4'h1;	// Last count before wrap
	localparam logic [REG_AW-1:0] TIM_R_CMPA   = 4'h2;
	localparam logic [REG_AW-1:0] TIM_R_CMPB   = 4'h3;
	localparam logic [REG_AW-1:0] TIM_R_COUNT  = 4'h4;	// Read only
	localparam int TIM_EN_BIT = 0;

	// Interrupt sources
	localparam int IRQ_N  = 8;	// Number of sources
	localparam int IRQ_VW = 3;	// Vector width
	localparam int IRQ_EXT0   = 0;
	localparam int IRQ_EXT1   = 1;
	localparam int IRQ_T0_OVF = 2;	// First timer event
	localparam int IRQ_T0_CMA = 3;
	localparam int IRQ_T0_CMB = 4;
	localparam int IRQ_T1_OVF = 5;
	localparam int IRQ_T1_CMA = 6;
	localparam int IRQ_T1_CMB = 7;

	localparam logic [REG_AW-1:0] INTC_R_PEND = 4'h0;	// Write one to clear
	localparam logic [REG_AW-1:0] INTC_R_ENB  = 4'h1;

endpackage

`default_nettype wire

/* logic/periph_bus.sv */
`default_nettype none

module periph_bus import mcoc_pkg::*; (
	input  wire logic              rd_i,	// Read command from master
	input  wire logic              wr_i,	// Write command from master
	input  wire logic [BUS_AW-1:0] adr_i,
	input  wire logic [BUS_DW-1:0] id_rdat_i,	// Registered read data per peripheral
	input  wire logic [BUS_DW-1:0] port_rdat_i,
	input  wire logic [BUS_DW-1:0] tim0_rdat_i,
	input  wire logic [BUS_DW-1:0] tim1_rdat_i,
	input  wire logic [BUS_DW-1:0] intc_rdat_i,
	output logic                   id_rd_o,	// Id block is read only
	output logic                   port_rd_o,
	output logic                   port_wr_o,
	output logic                   tim0_rd_o,
	output logic                   tim0_wr_o,
	output logic                   tim1_rd_o,
	output logic                   tim1_wr_o,
	output logic                   intc_rd_o,
	output logic                   intc_wr_o,
	output logic [REG_AW-1:0]      reg_o,	// Register index to all pages
	output logic [BUS_DW-1:0]      rdat_o	// Wired-OR return
);

	logic [PAGE_W-1:0] page;	// Upper address field
	logic              sel_id;
	logic              sel_port;
	logic              sel_tim0;
	logic              sel_tim1;
	logic              sel_intc;

	assign page  = adr_i[BUS_AW-1:REG_AW];
	assign reg_o = adr_i[REG_AW-1:0];

	// One select per page, other pages stay silent
	assign sel_id   = (page == PAGE_ID);
	assign sel_port = (page == PAGE_PORT);
	assign sel_tim0 = (page == PAGE_TIM0);
	assign sel_tim1 = (page == PAGE_TIM1);
	assign sel_intc = (page == PAGE_INTC);

	// Strobes already qualified by select
	assign id_rd_o   = rd_i & sel_id;
	assign port_rd_o = rd_i & sel_port;
	assign port_wr_o = wr_i & sel_port;
	assign tim0_rd_o = rd_i & sel_tim0;
	assign tim0_wr_o = wr_i & sel_tim0;
	assign tim1_rd_o = rd_i & sel_tim1;
	assign tim1_wr_o = wr_i & sel_tim1;
	assign intc_rd_o = rd_i & sel_intc;
	assign intc_wr_o = wr_i & sel_intc;

	// Unselected blocks hold zero so a plain OR is enough
	assign rdat_o = id_rdat_i | port_rdat_i | tim0_rdat_i | tim1_rdat_i | intc_rdat_i;

endmodule

`default_nettype wire

/* logic/id_regs.sv */
`default_nettype none

module id_regs import mcoc_pkg::*; (
	input  wire logic              clk,
	input  wire logic              arst_n_i,
	input  wire logic              rd_i,	// Selected read
	input  wire logic [REG_AW-1:0] reg_i,
	output logic [BUS_DW-1:0]      rdat_o
);

	logic [BUS_DW-1:0] id_val;	// Constant picked by offset

	always_comb begin
		case (reg_i)
			ID_R_CODE:    id_val = ID_CODE;
			ID_R_VERSION: id_val = ID_VERSION;
			ID_R_CLK:     id_val = ID_CLK_KHZ;
			ID_R_EDITION: id_val = ID_EDITION;
			default:      id_val = '0;	// Unmapped offsets read zero
		endcase
	end

	// Read data valid one cycle after the strobe, zero otherwise
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			rdat_o <= '0;
		end else begin
			rdat_o <= rd_i ? id_val : '0;
		end
	end

endmodule

`default_nettype wire

/* logic/gpio_port.sv */
`default_nettype none

module gpio_port import mcoc_pkg::*; (
	input  wire logic              clk,
	input  wire logic              arst_n_i,
	input  wire logic              rd_i,	// Selected read
	input  wire logic              wr_i,	// Selected write
	input  wire logic [REG_AW-1:0] reg_i,
	input  wire logic [PORT_W-1:0] wdat_i,	// Low byte of bus data
	input  wire logic [15:0]       pin_i,	// Low and high pin groups
	output logic [PORT_W-1:0]      out_o,
	output logic [PORT_W-1:0]      oe_o,
	output logic [BUS_DW-1:0]      rdat_o
);

	logic [PORT_W-1:0] sel_q;	// 1 picks pin k, 0 picks pin k+8
	logic [PORT_W-1:0] pin_mux;
	logic [PORT_W-1:0] inp_meta;	// First sync stage
	logic [PORT_W-1:0] inp_sync;	// Second sync stage
	logic [PORT_W-1:0] rd_val;

	// Per-bit group select
	assign pin_mux = (sel_q & pin_i[PORT_W-1:0]) | (~sel_q & pin_i[15:PORT_W]);

	// Control registers
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			out_o <= '0;
			oe_o  <= '0;	// All pins start as inputs
			sel_q <= '0;
		end else if (wr_i) begin
			case (reg_i)
				PORT_R_OUT: out_o <= wdat_i;
				PORT_R_ENB: oe_o  <= wdat_i;
				PORT_R_SEL: sel_q <= wdat_i;
				default: ;	// Input register ignores writes
			endcase
		end
	end

	// Two-flop input synchronizer
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			inp_meta <= '0;
			inp_sync <= '0;
		end else begin
			inp_meta <= pin_mux;
			inp_sync <= inp_meta;
		end
	end

	always_comb begin
		case (reg_i)
			PORT_R_OUT: rd_val = out_o;
			PORT_R_ENB: rd_val = oe_o;
			PORT_R_SEL: rd_val = sel_q;
			PORT_R_INP: rd_val = inp_sync;
			default:    rd_val = '0;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			rdat_o <= '0;
		end else begin
			rdat_o <= rd_i ? {{(BUS_DW-PORT_W){1'b0}}, rd_val} : '0;	// Zero when idle
		end
	end

endmodule

`default_nettype wire

/* logic/pwm_timer.sv */
`default_nettype none

module pwm_timer import mcoc_pkg::*; (
	input  wire logic              clk,
	input  wire logic              arst_n_i,
	input  wire logic              rd_i,	// Selected read
	input  wire logic              wr_i,	// Selected write
	input  wire logic [REG_AW-1:0] reg_i,
	input  wire logic [BUS_DW-1:0] wdat_i,
	output logic                   pwma_o,
	output logic                   pwmb_o,
	output logic                   ovf_o,	// One pulse per wrap
	output logic                   cma_o,	// Count hit CMPA
	output logic                   cmb_o,	// Count hit CMPB
	output logic [BUS_DW-1:0]      rdat_o
);

	logic              en_q;	// Run enable
	logic [BUS_DW-1:0] period_q;
	logic [BUS_DW-1:0] cmpa_q;
	logic [BUS_DW-1:0] cmpb_q;
	logic [BUS_DW-1:0] cnt_q;
	logic              wrap;	// Last count of the period
	logic [BUS_DW-1:0] rd_val;

	assign wrap = (cnt_q == period_q);

	// Configuration registers
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			en_q     <= 1'b0;
			period_q <= '0;
			cmpa_q   <= '0;
			cmpb_q   <= '0;
		end else if (wr_i) begin
			case (reg_i)
				TIM_R_CTRL:   en_q     <= wdat_i[TIM_EN_BIT];
				TIM_R_PERIOD: period_q <= wdat_i;
				TIM_R_CMPA:   cmpa_q   <= wdat_i;
				TIM_R_CMPB:   cmpb_q   <= wdat_i;
				default: ;	// COUNT is read only
			endcase
		end
	end

	// Counter 0..PERIOD, parked at 0 while stopped
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			cnt_q <= '0;
		end else if (!en_q || wrap) begin
			cnt_q <= '0;
		end else begin
			cnt_q <= cnt_q + 1'b1;
		end
	end

	// Event pulses registered for clean single-cycle strobes
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			ovf_o <= 1'b0;
			cma_o <= 1'b0;
			cmb_o <= 1'b0;
		end else begin
			ovf_o <= en_q & wrap;
			cma_o <= en_q & (cnt_q == cmpa_q);
			cmb_o <= en_q & (cnt_q == cmpb_q);
		end
	end

	// High for CMP counts of every PERIOD+1
	assign pwma_o = en_q & (cnt_q < cmpa_q);
	assign pwmb_o = en_q & (cnt_q < cmpb_q);

	always_comb begin
		case (reg_i)
			TIM_R_CTRL:   rd_val = {{(BUS_DW-1){1'b0}}, en_q};
			TIM_R_PERIOD: rd_val = period_q;
			TIM_R_CMPA:   rd_val = cmpa_q;
			TIM_R_CMPB:   rd_val = cmpb_q;
			TIM_R_COUNT:  rd_val = cnt_q;
			default:      rd_val = '0;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			rdat_o <= '0;
		end else begin
			rdat_o <= rd_i ? rd_val : '0;
		end
	end

endmodule

`default_nettype wire

/* logic/irq_ctrl.sv */
`default_nettype none

module irq_ctrl import mcoc_pkg::*; (
	input  wire logic              clk,
	input  wire logic              arst_n_i,
	input  wire logic              rd_i,	// Selected read
	input  wire logic              wr_i,	// Selected write
	input  wire logic [REG_AW-1:0] reg_i,
	input  wire logic [IRQ_N-1:0]  wdat_i,	// Low byte of bus data
	input  wire logic [1:0]        ext_i,	// Asynchronous request lines
	input  wire logic [5:0]        tim_evt_i,	// Timer events in source order
	output logic                   irq_o,
	output logic [IRQ_VW-1:0]      vec_o,
	output logic [BUS_DW-1:0]      rdat_o
);

	logic [1:0]       ext_meta;	// Sync stage 1
	logic [1:0]       ext_sync;	// Sync stage 2
	logic [1:0]       ext_prev;	// For edge detect
	logic [1:0]       ext_rise;
	logic [IRQ_N-1:0] src;	// All set requests
	logic [IRQ_N-1:0] clr;	// Write-one-to-clear mask
	logic [IRQ_N-1:0] pend_q;
	logic [IRQ_N-1:0] enb_q;
	logic [IRQ_N-1:0] act;	// Pending and enabled
	logic [IRQ_N-1:0] rd_val;

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			ext_meta <= '0;
			ext_sync <= '0;
			ext_prev <= '0;
		end else begin
			ext_meta <= ext_i;
			ext_sync <= ext_meta;
			ext_prev <= ext_sync;
		end
	end

	assign ext_rise = ext_sync & ~ext_prev;	// Rising edges only

	assign src[IRQ_EXT0]               = ext_rise[0];
	assign src[IRQ_EXT1]               = ext_rise[1];
	assign src[IRQ_N-1:IRQ_T0_OVF]     = tim_evt_i;
	assign clr = (wr_i && reg_i == INTC_R_PEND) ? wdat_i : '0;

	// New events win over a clear in the same cycle
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			pend_q <= '0;
			enb_q  <= '0;
		end else begin
			pend_q <= (pend_q & ~clr) | src;
			if (wr_i && reg_i == INTC_R_ENB) begin
				enb_q <= wdat_i;
			end
		end
	end

	assign act   = pend_q & enb_q;
	assign irq_o = |act;

	// Lowest active source number
	always_comb begin
		vec_o = '0;
		for (int i = IRQ_N - 1; i >= 0; i--) begin
			if (act[i]) begin
				vec_o = IRQ_VW'(i);
			end
		end
	end

	always_comb begin
		case (reg_i)
			INTC_R_PEND: rd_val = pend_q;
			INTC_R_ENB:  rd_val = enb_q;
			default:     rd_val = '0;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			rdat_o <= '0;
		end else begin
			rdat_o <= rd_i ? {{(BUS_DW-IRQ_N){1'b0}}, rd_val} : '0;
		end
	end

endmodule

`default_nettype wire

/* logic/mcoc_periph_top.sv */
`default_nettype none

module mcoc_periph_top import mcoc_pkg::*; (
	input  wire logic              clk,
	input  wire logic              arst_n_i,
	input  wire logic              rd_i,	// Master read command
	input  wire logic              wr_i,	// Master write command
	input  wire logic [BUS_AW-1:0] adr_i,
	input  wire logic [BUS_DW-1:0] wdat_i,
	output logic [BUS_DW-1:0]      rdat_o,	// Valid one cycle after rd_i
	input  wire logic [15:0]       port_in_i,	// Pin levels from the pads
	output logic [PORT_W-1:0]      port_out_o,
	output logic [PORT_W-1:0]      port_oe_o,
	input  wire logic [1:0]        ext_int_i,
	output logic                   tim0_pwma_o,
	output logic                   tim0_pwmb_o,
	output logic                   tim1_pwma_o,
	output logic                   tim1_pwmb_o,
	output logic                   irq_o,
	output logic [IRQ_VW-1:0]      vec_o
);

	logic [REG_AW-1:0] reg_idx;	// Shared register index
	logic              id_rd;
	logic              port_rd, port_wr;
	logic              tim0_rd, tim0_wr;
	logic              tim1_rd, tim1_wr;
	logic              intc_rd, intc_wr;
	logic [BUS_DW-1:0] id_rdat, port_rdat, tim0_rdat, tim1_rdat, intc_rdat;
	logic              tim0_ovf, tim0_cma, tim0_cmb;
	logic              tim1_ovf, tim1_cma, tim1_cmb;
	logic [5:0]        tim_evt;	// Ordered as IRQ_T0_OVF upward

	assign tim_evt = {tim1_cmb, tim1_cma, tim1_ovf, tim0_cmb, tim0_cma, tim0_ovf};

	periph_bus u_bus (
		.rd_i(rd_i), .wr_i(wr_i), .adr_i(adr_i),
		.id_rdat_i(id_rdat), .port_rdat_i(port_rdat),
		.tim0_rdat_i(tim0_rdat), .tim1_rdat_i(tim1_rdat), .intc_rdat_i(intc_rdat),
		.id_rd_o(id_rd), .port_rd_o(port_rd), .port_wr_o(port_wr),
		.tim0_rd_o(tim0_rd), .tim0_wr_o(tim0_wr),
		.tim1_rd_o(tim1_rd), .tim1_wr_o(tim1_wr),
		.intc_rd_o(intc_rd), .intc_wr_o(intc_wr),
		.reg_o(reg_idx), .rdat_o(rdat_o)
	);

	id_regs u_id (
		.clk(clk), .arst_n_i(arst_n_i), .rd_i(id_rd), .reg_i(reg_idx), .rdat_o(id_rdat)
	);

	gpio_port u_port (
		.clk(clk), .arst_n_i(arst_n_i), .rd_i(port_rd), .wr_i(port_wr),
		.reg_i(reg_idx), .wdat_i(wdat_i[PORT_W-1:0]), .pin_i(port_in_i),
		.out_o(port_out_o), .oe_o(port_oe_o), .rdat_o(port_rdat)
	);

	// Two identical timers on adjacent pages
	pwm_timer u_tim0 (
		.clk(clk), .arst_n_i(arst_n_i), .rd_i(tim0_rd), .wr_i(tim0_wr),
		.reg_i(reg_idx), .wdat_i(wdat_i),
		.pwma_o(tim0_pwma_o), .pwmb_o(tim0_pwmb_o),
		.ovf_o(tim0_ovf), .cma_o(tim0_cma), .cmb_o(tim0_cmb), .rdat_o(tim0_rdat)
	);

	pwm_timer u_tim1 (
		.clk(clk), .arst_n_i(arst_n_i), .rd_i(tim1_rd), .wr_i(tim1_wr),
		.reg_i(reg_idx), .wdat_i(wdat_i),
		.pwma_o(tim1_pwma_o), .pwmb_o(tim1_pwmb_o),
		.ovf_o(tim1_ovf), .cma_o(tim1_cma), .cmb_o(tim1_cmb), .rdat_o(tim1_rdat)
	);

	irq_ctrl u_intc (
		.clk(clk), .arst_n_i(arst_n_i), .rd_i(intc_rd), .wr_i(intc_wr),
		.reg_i(reg_idx), .wdat_i(wdat_i[IRQ_N-1:0]),
		.ext_i(ext_int_i), .tim_evt_i(tim_evt),
		.irq_o(irq_o), .vec_o(vec_o), .rdat_o(intc_rdat)
	);

endmodule

`default_nettype wire

/* verif/tb_top.sv */
`default_nettype none

module tb_top import mcoc_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	logic              clk;
	logic              arst_n_i;
	logic              rd_i;
	logic              wr_i;
	logic [15:0]       adr_i;
	logic [15:0]       wdat_i;
	logic [15:0]       rdat_o;
	logic [15:0]       port_in_i;
	logic [7:0]        port_out_o;
	logic [7:0]        port_oe_o;
	logic [1:0]        ext_int_i;
	logic              tim0_pwma_o, tim0_pwmb_o;
	logic              tim1_pwma_o, tim1_pwmb_o;
	logic              irq_o;
	logic [2:0]        vec_o;

	int checks = 0;	// Immediate checks run
	int errors = 0;	// Immediate check failures and timeouts
	int prop_errors = 0;	// Concurrent assertion failures

	mcoc_periph_top DUT (
		.clk(clk), .arst_n_i(arst_n_i), .rd_i(rd_i), .wr_i(wr_i),
		.adr_i(adr_i), .wdat_i(wdat_i), .rdat_o(rdat_o),
		.port_in_i(port_in_i), .port_out_o(port_out_o), .port_oe_o(port_oe_o),
		.ext_int_i(ext_int_i),
		.tim0_pwma_o(tim0_pwma_o), .tim0_pwmb_o(tim0_pwmb_o),
		.tim1_pwma_o(tim1_pwma_o), .tim1_pwmb_o(tim1_pwmb_o),
		.irq_o(irq_o), .vec_o(vec_o)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;	// 40 ns period
	end

	// Read data shows only in the cycle right after a read
	assert property (@(posedge clk) disable iff (!arst_n_i) !$past(rd_i) |-> rdat_o == 16'h0000)
		else begin
			prop_errors++;
			$display("[ERROR] rdat_o got %h expected 0000 in a cycle not after a read", rdat_o);
		end

	task automatic next_cycle();
		@(posedge clk);
		#2;	// Drive and sample off the edge
	endtask

	task automatic check_val(input string name, input logic [15:0] got, input logic [15:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("[ERROR] %s got %h expected %h", name, got, exp);
		end
	endtask

	function automatic logic [15:0] addr(input logic [11:0] page, input logic [3:0] r);
		return {page, r};
	endfunction

	// Pin k when select bit k is set, else pin k+8
	function automatic logic [7:0] pick_pins(input logic [7:0] sel, input logic [15:0] pins);
		logic [7:0] res;
		for (int k = 0; k < 8; k++) begin
			res[k] = sel[k] ? pins[k] : pins[k + 8];
		end
		return res;
	endfunction

	task automatic bus_write(input logic [15:0] a, input logic [15:0] d);
		next_cycle();
		wr_i   = 1'b1;
		adr_i  = a;
		wdat_i = d;
		next_cycle();	// Write taken at this edge
		wr_i   = 1'b0;
	endtask

	task automatic bus_read(input logic [15:0] a, output logic [15:0] d);
		next_cycle();
		rd_i  = 1'b1;
		adr_i = a;
		next_cycle();
		rd_i  = 1'b0;
		d     = rdat_o;	// Registered at the edge just passed
	endtask

	task automatic wait_irq(input int max_cycles, input string what);
		int n;
		n = 0;
		while (!irq_o && n < max_cycles) begin
			next_cycle();
			n++;
		end
		if (!irq_o) begin
			errors++;
			$display("Timeout: irq_o did not rise while waiting for %s", what);
		end
	endtask

	// Runs one timer over four periods and counts PWM high cycles
	task automatic pwm_run(input logic [11:0] page, input bit tim1);
		int per;
		int cmpa;
		int cmpb;
		int high_a;
		int high_b;
		per  = 4 + int'($urandom % 13);
		cmpa = 1 + int'($urandom % per);	// 1..per
		cmpb = 1 + int'($urandom % per);
		high_a = 0;
		high_b = 0;
		bus_write(addr(page, TIM_R_PERIOD), 16'(per));
		bus_write(addr(page, TIM_R_CMPA), 16'(cmpa));
		bus_write(addr(page, TIM_R_CMPB), 16'(cmpb));
		bus_write(addr(page, TIM_R_CTRL), 16'h0001);
		repeat (4 * (per + 1)) begin
			next_cycle();
			if (tim1 ? tim1_pwma_o : tim0_pwma_o) high_a++;
			if (tim1 ? tim1_pwmb_o : tim0_pwmb_o) high_b++;
		end
		check_val("pwma high cycles", 16'(high_a), 16'(4 * cmpa));
		check_val("pwmb high cycles", 16'(high_b), 16'(4 * cmpb));
		bus_write(addr(page, TIM_R_CTRL), 16'h0000);	// Stop forces outputs low
		repeat (2) begin
			check_val("pwma_o", {15'h0, tim1 ? tim1_pwma_o : tim0_pwma_o}, 16'h0000);
			check_val("pwmb_o", {15'h0, tim1 ? tim1_pwmb_o : tim0_pwmb_o}, 16'h0000);
			next_cycle();	// Counter parked at 0 from here
		end
	endtask

	initial begin
		logic [15:0] rd;
		logic [7:0]  val;
		logic [7:0]  enb;
		logic [15:0] pins;
		rd_i      = 1'b0;
		wr_i      = 1'b0;
		adr_i     = '0;
		wdat_i    = '0;
		port_in_i = '0;
		ext_int_i = '0;
		arst_n_i  = 1'b0;
		void'($urandom(86854));
		repeat (8) @(posedge clk);
		#2 arst_n_i = 1'b1;

		// Reset state
		check_val("port_out_o", {8'h00, port_out_o}, 16'h0000);
		check_val("port_oe_o", {8'h00, port_oe_o}, 16'h0000);
		check_val("pwm outputs", {12'h000, tim0_pwma_o, tim0_pwmb_o, tim1_pwma_o, tim1_pwmb_o},
			16'h0000);
		check_val("irq_o", {15'h0, irq_o}, 16'h0000);
		check_val("vec_o", {13'h0, vec_o}, 16'h0000);
		check_val("rdat_o", rdat_o, 16'h0000);

		// Identification block and unmapped space
		bus_read(addr(PAGE_ID, 4'h0), rd);
		check_val("rdat_o ID code", rd, 16'h1150);
		bus_read(addr(PAGE_ID, 4'h1), rd);
		check_val("rdat_o ID version", rd, 16'h0148);
		bus_read(addr(PAGE_ID, 4'h2), rd);
		check_val("rdat_o ID clock", rd, 16'd24000);
		bus_read(addr(PAGE_ID, 4'h3), rd);
		check_val("rdat_o ID edition", rd, 16'h4c41);	// ASCII "LA"
		bus_read(addr(PAGE_ID, 4'h5), rd);
		check_val("rdat_o ID offset 5", rd, 16'h0000);
		bus_read(addr(12'hff8, 4'h0), rd);
		check_val("rdat_o page ff8", rd, 16'h0000);
		bus_read(addr(12'h000, 4'h1), rd);
		check_val("rdat_o page 000", rd, 16'h0000);

		// Port outputs and enables
		for (int i = 0; i < 4; i++) begin
			val = 8'($urandom);
			enb = 8'($urandom);
			bus_write(addr(PAGE_PORT, PORT_R_OUT), {8'h00, val});
			check_val("port_out_o", {8'h00, port_out_o}, {8'h00, val});
			bus_write(addr(PAGE_PORT, PORT_R_ENB), {8'h00, enb});
			check_val("port_oe_o", {8'h00, port_oe_o}, {8'h00, enb});
			bus_read(addr(PAGE_PORT, PORT_R_OUT), rd);
			check_val("rdat_o port out", rd, {8'h00, val});
			bus_read(addr(PAGE_PORT, PORT_R_ENB), rd);
			check_val("rdat_o port enable", rd, {8'h00, enb});
		end

		// Port input select
		for (int i = 0; i < 6; i++) begin
			val  = 8'($urandom);
			pins = 16'($urandom);
			bus_write(addr(PAGE_PORT, PORT_R_SEL), {8'h00, val});
			port_in_i = pins;
			repeat (3) next_cycle();	// Pins settle through the sync flops
			bus_read(addr(PAGE_PORT, PORT_R_INP), rd);
			check_val("rdat_o port input", rd, {8'h00, pick_pins(val, pins)});
		end

		// PWM on both timers
		pwm_run(PAGE_TIM0, 1'b0);
		pwm_run(PAGE_TIM1, 1'b1);

		// Timer 0 overflow interrupt
		bus_write(addr(PAGE_INTC, INTC_R_ENB), 16'h0004);
		bus_write(addr(PAGE_INTC, INTC_R_PEND), 16'h00ff);	// Drop events left from PWM runs
		check_val("irq_o", {15'h0, irq_o}, 16'h0000);
		bus_write(addr(PAGE_TIM0, TIM_R_CMPA), 16'hffff);	// Compares never hit
		bus_write(addr(PAGE_TIM0, TIM_R_CMPB), 16'hffff);
		bus_write(addr(PAGE_TIM0, TIM_R_PERIOD), 16'd10);
		bus_write(addr(PAGE_TIM0, TIM_R_CTRL), 16'h0001);
		wait_irq(100, "timer 0 overflow");
		check_val("vec_o", {13'h0, vec_o}, 16'h0002);
		bus_write(addr(PAGE_TIM0, TIM_R_CTRL), 16'h0000);
		repeat (3) next_cycle();	// Let a last overflow pulse land
		bus_read(addr(PAGE_INTC, INTC_R_PEND), rd);
		check_val("rdat_o pending", rd, 16'h0004);
		bus_write(addr(PAGE_INTC, INTC_R_PEND), 16'h0004);
		check_val("irq_o", {15'h0, irq_o}, 16'h0000);

		// External requests, only line 1 enabled
		bus_write(addr(PAGE_INTC, INTC_R_ENB), 16'h0002);
		bus_write(addr(PAGE_INTC, INTC_R_PEND), 16'h00ff);
		ext_int_i[0] = 1'b1;
		for (int i = 0; i < 8; i++) begin
			next_cycle();
			check_val("irq_o", {15'h0, irq_o}, 16'h0000);	// Line 0 not enabled
		end
		bus_read(addr(PAGE_INTC, INTC_R_PEND), rd);
		check_val("rdat_o pending", rd, 16'h0001);
		ext_int_i[1] = 1'b1;
		wait_irq(10, "external request 1");
		check_val("vec_o", {13'h0, vec_o}, 16'h0001);
		ext_int_i = 2'b00;
		bus_write(addr(PAGE_INTC, INTC_R_PEND), 16'h00ff);
		check_val("irq_o", {15'h0, irq_o}, 16'h0000);

		next_cycle();
		$display("Checks: %0d, check errors: %0d, assertion errors: %0d",
			checks, errors, prop_errors);
		if (errors == 0 && prop_errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* list.f */
logic/mcoc_pkg.sv
logic/periph_bus.sv
logic/id_regs.sv
logic/gpio_port.sv
logic/pwm_timer.sv
logic/irq_ctrl.sv
logic/mcoc_periph_top.sv
verif/tb_top.sv

/* Makefile */
# Verilator build and run for the peripheral subsystem
VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(wildcard logic/*.sv) $(wildcard verif/*.sv)
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes
$(OBJ_DIR)/V%: $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $* -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$*

run: $(SIM)
	$(SIM) 2>&1 | tee $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "TESTBENCH PASSED" $(LOG) || (echo "No pass message in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
